/* rtl/nco_pkg.sv */
`default_nettype none

package nco_pkg;

  // phase accumulator and increment width
  localparam int PHASE_W = 32;

  // signed sine, cosine and CORDIC x/y width
  localparam int OUT_W = 10;

  // signed CORDIC residual angle width
  localparam int ANGLE_W = 10;

  // angle inside one quadrant, 512 units make a quarter turn
  localparam int QANGLE_W = 9;
  localparam int FRAC_W = PHASE_W - 2 - QANGLE_W;

  localparam int N_STAGES = 10;

  // full scale divided by the CORDIC gain, so the result lands near 505
  localparam int CORDIC_X0 = 307;

  // atan(2^-i) in quarter-turn units of 512
  localparam int ATAN_TABLE [N_STAGES] = '{256, 151, 79, 40, 20, 10, 5, 2, 1, 0};

  typedef logic [1:0] quadrant_t;

  typedef struct packed {
    quadrant_t             quad;
    logic [QANGLE_W-1:0]   angle;
    logic [FRAC_W-1:0]     frac;
  } phase_fields_t;

  // the adder sees the raw word, the CORDIC start sees the split fields
  typedef union packed {
    logic [PHASE_W-1:0] raw;
    phase_fields_t      fields;
  } nco_phase_u;

endpackage

`default_nettype wire

/* rtl/cordic_stage_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one CORDIC vector between two pipeline stages
interface cordic_stage_if #(
  parameter int OUT_W   = nco_pkg::OUT_W,
  parameter int ANGLE_W = nco_pkg::ANGLE_W
);

  logic signed [OUT_W-1:0]   x;
  logic signed [OUT_W-1:0]   y;
  logic signed [ANGLE_W-1:0] z;
  logic                      valid;

  modport src (
    output x, y, z, valid
  );

  modport dst (
    input x, y, z, valid
  );

endinterface

`default_nettype wire

/* rtl/phase_accum.sv */
`timescale 1ns/100ps
`default_nettype none

module phase_accum #(
  parameter int PHASE_W = nco_pkg::PHASE_W
) (
  input  wire                  clk,
  input  wire                  arst_n_i,
  input  wire                  clken_i,
  input  wire  [PHASE_W-1:0]   phase_inc_i,
  output nco_pkg::nco_phase_u  phase_o,
  output logic                 valid_o
);

  // the sum wraps naturally at 2^PHASE_W
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_o.raw <= '0;
    end else if (clken_i) begin
      phase_o.raw <= phase_o.raw + phase_inc_i;
    end
  end

  // first enabled cycle after reset loads the first real phase
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else if (clken_i) begin
      valid_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/cordic_init.sv */
`timescale 1ns/100ps
`default_nettype none

module cordic_init (
  input  wire                 clk,
  input  wire                 arst_n_i,
  input  wire                 clken_i,
  input  nco_pkg::nco_phase_u phase_i,
  input  wire                 valid_i,
  output nco_pkg::quadrant_t  quad_o,
  cordic_stage_if.src         vec_o
);

  import nco_pkg::*;

  // the rotation always starts from the positive x axis, pre-scaled by 1/gain
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vec_o.x     <= '0;
      vec_o.y     <= '0;
      vec_o.z     <= '0;
      vec_o.valid <= 1'b0;
      quad_o      <= '0;
    end else if (clken_i) begin
      vec_o.x     <= OUT_W'(CORDIC_X0);
      vec_o.y     <= '0;
      vec_o.z     <= ANGLE_W'(phase_i.fields.angle);
      vec_o.valid <= valid_i;
      quad_o      <= phase_i.fields.quad;
    end
  end

endmodule

`default_nettype wire

/* rtl/cordic_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module cordic_stage #(
  parameter int OUT_W   = nco_pkg::OUT_W,
  parameter int ANGLE_W = nco_pkg::ANGLE_W,
  parameter int SHIFT   = 0
) (
  input  wire         clk,
  input  wire         arst_n_i,
  input  wire         clken_i,
  cordic_stage_if.dst in_if,
  cordic_stage_if.src out_if
);

  import nco_pkg::*;

  localparam logic signed [ANGLE_W-1:0] ATAN = ANGLE_W'(ATAN_TABLE[SHIFT]);

  logic                    z_neg;
  logic signed [OUT_W-1:0] x_sh;
  logic signed [OUT_W-1:0] y_sh;

  // a negative residual means the vector went past the target, so turn back
  assign z_neg = in_if.z[ANGLE_W-1];
  assign x_sh  = in_if.x >>> SHIFT;
  assign y_sh  = in_if.y >>> SHIFT;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_if.x     <= '0;
      out_if.y     <= '0;
      out_if.z     <= '0;
      out_if.valid <= 1'b0;
    end else if (clken_i) begin
      if (z_neg) begin
        out_if.x <= in_if.x + y_sh;
        out_if.y <= in_if.y - x_sh;
        out_if.z <= in_if.z + ATAN;
      end else begin
        out_if.x <= in_if.x - y_sh;
        out_if.y <= in_if.y + x_sh;
        out_if.z <= in_if.z - ATAN;
      end
      out_if.valid <= in_if.valid;
    end
  end

endmodule

`default_nettype wire

/* rtl/cordic_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module cordic_pipeline #(
  parameter int N_STAGES = nco_pkg::N_STAGES
) (
  input  wire                                clk,
  input  wire                                arst_n_i,
  input  wire                                clken_i,
  cordic_stage_if.dst                        vec_i,
  input  nco_pkg::quadrant_t                 quad_i,
  output logic signed [nco_pkg::OUT_W-1:0]   x_o,
  output logic signed [nco_pkg::OUT_W-1:0]   y_o,
  output nco_pkg::quadrant_t                 quad_o,
  output logic                               valid_o
);

  import nco_pkg::*;

  localparam logic signed [OUT_W-1:0] OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};

  quadrant_t quad_q [N_STAGES];

  cordic_stage_if #(.OUT_W(OUT_W), .ANGLE_W(ANGLE_W)) stg_if [N_STAGES] ();

  for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
    if (i == 0) begin : g_first
      cordic_stage #(.OUT_W(OUT_W), .ANGLE_W(ANGLE_W), .SHIFT(i)) u_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clken_i  (clken_i),
        .in_if    (vec_i),
        .out_if   (stg_if[i])
      );
    end else begin : g_next
      cordic_stage #(.OUT_W(OUT_W), .ANGLE_W(ANGLE_W), .SHIFT(i)) u_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clken_i  (clken_i),
        .in_if    (stg_if[i-1]),
        .out_if   (stg_if[i])
      );
    end
  end

  // the quadrant rides one register per stage so it meets its own vector
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      quad_q <= '{default: '0};
    end else if (clken_i) begin
      quad_q[0] <= quad_i;
      for (int i = 1; i < N_STAGES; i++) begin
        quad_q[i] <= quad_q[i-1];
      end
    end
  end

  assign x_o     = stg_if[N_STAGES-1].x;
  assign y_o     = stg_if[N_STAGES-1].y;
  assign valid_o = stg_if[N_STAGES-1].valid;
  assign quad_o  = quad_q[N_STAGES-1];

  // quadrant_fix negates these, which only works if the most negative code never shows up
  a_result_in_range: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    valid_o |-> (x_o != OUT_MIN) && (y_o != OUT_MIN)
  ) else $error("cordic_pipeline: result outside output range");

endmodule

`default_nettype wire

/* rtl/quadrant_fix.sv */
`timescale 1ns/100ps
`default_nettype none

module quadrant_fix (
  input  wire                                clk,
  input  wire                                arst_n_i,
  input  wire                                clken_i,
  input  wire signed [nco_pkg::OUT_W-1:0]    x_i,
  input  wire signed [nco_pkg::OUT_W-1:0]    y_i,
  input  nco_pkg::quadrant_t                 quad_i,
  input  wire                                valid_i,
  output logic signed [nco_pkg::OUT_W-1:0]   sin_o,
  output logic signed [nco_pkg::OUT_W-1:0]   cos_o,
  output logic                               valid_o
);

  // each quadrant is a quarter-turn rotation of the first-quadrant result
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sin_o   <= '0;
      cos_o   <= '0;
      valid_o <= 1'b0;
    end else if (clken_i) begin
      case (quad_i)
        2'd0: begin
          cos_o <= x_i;
          sin_o <= y_i;
        end
        2'd1: begin
          cos_o <= -y_i;
          sin_o <= x_i;
        end
        2'd2: begin
          cos_o <= -x_i;
          sin_o <= -y_i;
        end
        default: begin
          cos_o <= y_i;
          sin_o <= -x_i;
        end
      endcase
      valid_o <= valid_i;
    end
  end

  // without back-pressure the stream never has a gap once it has started
  a_valid_sticky: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    valid_o |=> valid_o
  ) else $error("quadrant_fix: valid dropped after start");

endmodule

`default_nettype wire

/* rtl/nco_top.sv */
`timescale 1ns/100ps
`default_nettype none

module nco_top #(
  parameter int PHASE_W  = nco_pkg::PHASE_W,
  parameter int N_STAGES = nco_pkg::N_STAGES
) (
  input  wire                                clk,
  input  wire                                arst_n_i,
  input  wire                                clken_i,
  input  wire  [PHASE_W-1:0]                 phase_inc_i,
  output logic signed [nco_pkg::OUT_W-1:0]   sin_o,
  output logic signed [nco_pkg::OUT_W-1:0]   cos_o,
  output logic                               out_valid_o
);

  import nco_pkg::*;

  nco_phase_u              phase;
  logic                    phase_valid;
  quadrant_t               init_quad;
  quadrant_t               pipe_quad;
  logic signed [OUT_W-1:0] pipe_x;
  logic signed [OUT_W-1:0] pipe_y;
  logic                    pipe_valid;

  cordic_stage_if #(.OUT_W(OUT_W), .ANGLE_W(ANGLE_W)) init_vec ();

  phase_accum #(.PHASE_W(PHASE_W)) u_phase_accum (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .clken_i     (clken_i),
    .phase_inc_i (phase_inc_i),
    .phase_o     (phase),
    .valid_o     (phase_valid)
  );

  cordic_init u_cordic_init (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .clken_i  (clken_i),
    .phase_i  (phase),
    .valid_i  (phase_valid),
    .quad_o   (init_quad),
    .vec_o    (init_vec)
  );

  cordic_pipeline #(.N_STAGES(N_STAGES)) u_cordic_pipeline (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .clken_i  (clken_i),
    .vec_i    (init_vec),
    .quad_i   (init_quad),
    .x_o      (pipe_x),
    .y_o      (pipe_y),
    .quad_o   (pipe_quad),
    .valid_o  (pipe_valid)
  );

  quadrant_fix u_quadrant_fix (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .clken_i  (clken_i),
    .x_i      (pipe_x),
    .y_i      (pipe_y),
    .quad_i   (pipe_quad),
    .valid_i  (pipe_valid),
    .sin_o    (sin_o),
    .cos_o    (cos_o),
    .valid_o  (out_valid_o)
  );

endmodule

`default_nettype wire

/* dv/nco_model.svh */
`ifndef NCO_MODEL_SVH
`define NCO_MODEL_SVH

// bit-exact reference of the whole NCO, included inside the testbench module

typedef struct packed {
  logic                    valid;
  logic signed [OUT_W-1:0] sin;
  logic signed [OUT_W-1:0] cos;
} nco_sample_t;

logic [PHASE_W-1:0] model_phase;
nco_sample_t        model_q[$];

// Galois form of x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
  return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

function automatic nco_sample_t nco_eval(input logic [PHASE_W-1:0] phase, input logic valid);
  int          x;
  int          y;
  int          z;
  int          x_prev;
  nco_sample_t s;
  x = CORDIC_X0;
  y = 0;
  z = int'(phase[PHASE_W-3 -: QANGLE_W]);
  for (int i = 0; i < N_STAGES; i++) begin
    x_prev = x;
    // rotate against the sign of the residual angle, driving it toward zero
    if (z < 0) begin
      x = x + (y >>> i);
      y = y - (x_prev >>> i);
      z = z + ATAN_TABLE[i];
    end else begin
      x = x - (y >>> i);
      y = y + (x_prev >>> i);
      z = z - ATAN_TABLE[i];
    end
  end
  // every quadrant adds a quarter turn, which maps (c, s) to (-s, c)
  for (int q = 0; q < int'(phase[PHASE_W-1 -: 2]); q++) begin
    x_prev = x;
    x = -y;
    y = x_prev;
  end
  s.valid = valid;
  s.cos   = OUT_W'(x);
  s.sin   = OUT_W'(y);
  return s;
endfunction

task automatic model_reset();
  model_phase = '0;
  model_q.delete();
  // eleven zero outputs from the cleared pipeline, then the reset phase flagged invalid
  repeat (N_STAGES + 1) begin
    model_q.push_back('0);
  end
  model_q.push_back(nco_eval('0, 1'b0));
endtask

task automatic model_advance(input logic [PHASE_W-1:0] inc, output nco_sample_t sample);
  model_phase = model_phase + inc;
  model_q.push_back(nco_eval(model_phase, 1'b1));
  sample = model_q.pop_front();
endtask

`endif

/* dv/nco_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module nco_tb;

  import nco_pkg::*;

  `include "nco_model.svh"

  localparam int RUN_LEN    = 600;
  localparam int ZERO_LEN   = 30;
  // enabled edge on which the first real sample leaves the pipeline
  localparam int VALID_EDGE = 13;
  localparam int TOTAL_LEN  = 3 + VALID_EDGE + 3 * RUN_LEN + 1 + ZERO_LEN;
  localparam int TIMEOUT    = 2 * TOTAL_LEN + 50;
  localparam int AMP_SQ     = 505 * 505;

  logic                    clk = 1'b0;
  logic                    arst_n_i;
  logic                    clken_i;
  logic [PHASE_W-1:0]      phase_inc_i;
  logic signed [OUT_W-1:0] sin_o;
  logic signed [OUT_W-1:0] cos_o;
  logic                    out_valid_o;

  logic [15:0]             lfsr_state = 16'd27102;
  nco_sample_t             expected;
  logic [3:0]              quads_seen;
  logic                    en_bit;
  logic signed [OUT_W-1:0] prev_sin;
  logic signed [OUT_W-1:0] prev_cos;
  logic signed [OUT_W-1:0] held_sin;
  logic signed [OUT_W-1:0] held_cos;
  int                      cycles = 0;
  int                      test_errors = 0;
  int                      total_errors = 0;
  int                      tests_run = 0;
  int                      tests_failed = 0;

  nco_top #(.PHASE_W(PHASE_W), .N_STAGES(N_STAGES)) u_dut (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .clken_i     (clken_i),
    .phase_inc_i (phase_inc_i),
    .sin_o       (sin_o),
    .cos_o       (cos_o),
    .out_valid_o (out_valid_o)
  );

  // the clock starts low from its declaration, so time zero carries no edge
  initial begin
    forever begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // one LFSR step per bit, newest bit in the LSB
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  task automatic check_value(input string what, input int got, input int want);
    assert (got == want) else begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, what, got, want);
      test_errors++;
    end
  endtask

  // drives one cycle from a falling edge and checks at the next falling edge
  task automatic apply_cycle(input logic en, input logic [PHASE_W-1:0] inc);
    int s;
    int c;
    int p;
    clken_i     = en;
    phase_inc_i = inc;
    prev_sin    = sin_o;
    prev_cos    = cos_o;
    @(posedge clk);
    if (en) begin
      model_advance(inc, expected);
      quads_seen[model_phase[PHASE_W-1 -: 2]] = 1'b1;
    end
    @(negedge clk);
    check_value("out_valid_o", int'(out_valid_o), int'(expected.valid));
    check_value("sin_o", int'(sin_o), int'(expected.sin));
    check_value("cos_o", int'(cos_o), int'(expected.cos));
    if (!en) begin
      check_value("sin_o during stall", int'(sin_o), int'(prev_sin));
      check_value("cos_o during stall", int'(cos_o), int'(prev_cos));
    end
    s = int'(sin_o);
    c = int'(cos_o);
    p = s * s + c * c;
    // the squared magnitude sits within 12 percent of full scale squared
    assert (!out_valid_o || (p * 100 >= AMP_SQ * 88 && p * 100 <= AMP_SQ * 112)) else begin
      $display("** Error at %0t: sin^2 + cos^2 = %0d, beyond 12 %% of %0d", $time, p, AMP_SQ);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d, %s: passed", tests_run, name);
    end else begin
      $display("test %0d, %s: failed with %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    arst_n_i    = 1'b0;
    clken_i     = 1'b0;
    phase_inc_i = '0;
    expected    = '0;
    quads_seen  = '0;
    model_reset();
    repeat (2) begin
      @(negedge clk);
      check_value("sin_o in reset", int'(sin_o), 0);
      check_value("cos_o in reset", int'(cos_o), 0);
      check_value("out_valid_o in reset", int'(out_valid_o), 0);
    end
    arst_n_i = 1'b1;
    apply_cycle(1'b0, '0);
    finish_test("reset");

    for (int n = 1; n <= VALID_EDGE; n++) begin
      apply_cycle(1'b1, take_bits(32));
      check_value("out_valid_o latency", int'(out_valid_o), int'(n == VALID_EDGE));
    end
    finish_test("valid latency");

    quads_seen = '0;
    repeat (RUN_LEN) begin
      apply_cycle(1'b1, take_bits(32));
    end
    assert (quads_seen == 4'hF) else begin
      $display("the random increments did not reach all four quadrants");
      test_errors++;
    end
    finish_test("bit-exact output");

    repeat (RUN_LEN) begin
      en_bit = take_bits(1) != 0;
      apply_cycle(en_bit, take_bits(32));
    end
    finish_test("stall");

    // smaller steps sweep the circle finely over a few turns
    repeat (RUN_LEN) begin
      apply_cycle(1'b1, take_bits(26));
    end
    finish_test("amplitude");

    apply_cycle(1'b1, take_bits(32));
    for (int n = 1; n <= ZERO_LEN; n++) begin
      apply_cycle(1'b1, '0);
      if (n == VALID_EDGE) begin
        held_sin = sin_o;
        held_cos = cos_o;
      end else if (n > VALID_EDGE) begin
        check_value("sin_o with zero increment", int'(sin_o), int'(held_sin));
        check_value("cos_o with zero increment", int'(cos_o), int'(held_cos));
      end
    end
    finish_test("zero increment");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* nco_top.f */
+incdir+dv
rtl/nco_pkg.sv
rtl/cordic_stage_if.sv
rtl/phase_accum.sv
rtl/cordic_init.sv
rtl/cordic_stage.sv
rtl/cordic_pipeline.sv
rtl/quadrant_fix.sv
rtl/nco_top.sv
dv/nco_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the NCO testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module nco_tb -f nco_top.f -o nco_sim \
  && ./obj_dir/nco_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1
exit 0
